// File: Makefile
TOP = mem_subsystem_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f sources.f --top-module mem_subsystem

sim:
	verilator --binary --timing --assert -f sources.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -q "Simulation PASSED"

clean:
	rm -rf obj_dir

// File: design/fetch_unit.sv
`default_nettype none

module fetch_unit #(
    parameter mem_pkg::xlen_t RESET_PC = '0
) (
    input  wire logic            clock,
    input  wire logic            reset,
    input  wire logic            take_branch,
    input  wire mem_pkg::xlen_t  branch_target,
    mem_port_if.requester        port,
    output logic                 fetch_valid,
    output mem_pkg::xlen_t       fetch_pc,
    output mem_pkg::word_t       fetch_inst
);

    // idle presents the request, wait holds the one outstanding load
    typedef enum logic {
        FETCH_IDLE,
        FETCH_WAIT
    } fetch_state_e;

    fetch_state_e   state;
    mem_pkg::xlen_t pc;
    // reply of the load in flight is stale
    logic           squash;
    // set one edge after reset releases
    logic           fetch_on;

    ////////////////////////////////////////////////////////////
    // request side
    ////////////////////////////////////////////////////////////

    assign port.command = (state == FETCH_IDLE && fetch_on) ? mem_pkg::BUS_LOAD
                                                             : mem_pkg::BUS_NONE;
    // whole block holding pc
    assign port.addr    = {pc[31:3], 3'b000};
    assign port.data    = '0;
    assign port.size    = mem_pkg::SIZE_DOUBLE;

    ////////////////////////////////////////////////////////////
    // delivery
    ////////////////////////////////////////////////////////////

    // a branch in the reply cycle also kills the reply
    assign fetch_valid = port.reply_valid && !squash && !take_branch;
    assign fetch_pc    = pc;
    // pc bit 2 picks the word inside the block
    assign fetch_inst  = pc[2] ? port.reply_data[63:32] : port.reply_data[31:0];

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            state    <= FETCH_IDLE;
            pc       <= RESET_PC;
            squash   <= 1'b0;
            fetch_on <= 1'b0;
        end else begin
            fetch_on <= 1'b1;
            case (state)
                FETCH_IDLE: begin
                    if (port.accepted) begin
                        state  <= FETCH_WAIT;
                        // load just taken is already for the old pc
                        squash <= take_branch;
                    end
                end
                FETCH_WAIT: begin
                    if (port.reply_valid) begin
                        state  <= FETCH_IDLE;
                        squash <= 1'b0;
                    end else if (take_branch) begin
                        squash <= 1'b1;
                    end
                end
                default: begin
                    state <= FETCH_IDLE;
                end
            endcase
            // redirect beats the sequential step
            if (take_branch) begin
                pc <= branch_target;
            end else if (fetch_valid) begin
                pc <= pc + 32'd4;
            end
        end
    end

    // arbiter must never route a block here with nothing out
    no_reply_in_idle: assert property (@(posedge clock) disable iff (reset)
        port.reply_valid |-> (state == FETCH_WAIT))
        else $error("fetch reply while no load outstanding");

endmodule

`default_nettype wire

// File: design/load_store_queue.sv
`default_nettype none

module load_store_queue #(
    parameter int LSQ_DEPTH = 4
) (
    input  wire logic              clock,
    input  wire logic              reset,
    input  wire logic              mem_op_valid,
    input  wire logic              mem_op_store,
    input  wire mem_pkg::xlen_t    mem_op_addr,
    input  wire mem_pkg::word_t    mem_op_data,
    input  wire mem_pkg::op_tag_t  mem_op_tag,
    mem_port_if.requester          port,
    output logic                   lsq_free,
    output logic                   load_done,
    output mem_pkg::op_tag_t       load_tag,
    output mem_pkg::word_t         load_data
);

    // depth is a power of two, pointers wrap on their own
    localparam int PTR_W = $clog2(LSQ_DEPTH);
    localparam int CNT_W = PTR_W + 1;

    // ready presents the head, wait holds for a load reply
    typedef enum logic {
        LSQ_READY,
        LSQ_WAIT
    } lsq_state_e;

    // entry storage
    logic             q_store [LSQ_DEPTH];
    mem_pkg::xlen_t   q_addr  [LSQ_DEPTH];
    mem_pkg::word_t   q_data  [LSQ_DEPTH];
    mem_pkg::op_tag_t q_tag   [LSQ_DEPTH];

    logic [PTR_W-1:0] head;
    logic [PTR_W-1:0] tail;
    logic [CNT_W-1:0] count;
    lsq_state_e       state;

    logic             has_head;
    logic             head_store;
    mem_pkg::xlen_t   head_addr;
    logic             enq;
    logic             deq;

    ////////////////////////////////////////////////////////////
    // head entry to memory
    ////////////////////////////////////////////////////////////

    assign has_head   = count != '0;
    assign head_store = q_store[head];
    assign head_addr  = q_addr[head];

    always_comb begin
        port.command = mem_pkg::BUS_NONE;
        if (has_head && state == LSQ_READY) begin
            port.command = head_store ? mem_pkg::BUS_STORE : mem_pkg::BUS_LOAD;
        end
    end

    // loads fetch the whole block, stores keep bit 2 for lane select
    assign port.addr = head_store ? head_addr : {head_addr[31:3], 3'b000};
    assign port.data = q_data[head];
    assign port.size = head_store ? mem_pkg::SIZE_WORD : mem_pkg::SIZE_DOUBLE;

    ////////////////////////////////////////////////////////////
    // load result
    ////////////////////////////////////////////////////////////

    assign load_done = (state == LSQ_WAIT) && port.reply_valid;
    assign load_tag  = q_tag[head];
    // addr bit 2 picks the word
    assign load_data = head_addr[2] ? port.reply_data[63:32] : port.reply_data[31:0];

    ////////////////////////////////////////////////////////////
    // queue bookkeeping
    ////////////////////////////////////////////////////////////

    assign lsq_free = count < CNT_W'(LSQ_DEPTH);
    assign enq      = mem_op_valid && lsq_free;
    // store leaves when accepted, load when its reply lands
    assign deq      = (has_head && state == LSQ_READY && head_store && port.accepted)
                    || load_done;

    always_ff @(posedge clock) begin
        if (enq) begin
            q_store[tail] <= mem_op_store;
            q_addr[tail]  <= mem_op_addr;
            q_data[tail]  <= mem_op_data;
            q_tag[tail]   <= mem_op_tag;
        end
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
            state <= LSQ_READY;
        end else begin
            if (enq) begin
                tail <= tail + PTR_W'(1);
            end
            if (deq) begin
                head <= head + PTR_W'(1);
            end
            count <= count + CNT_W'(enq) - CNT_W'(deq);
            case (state)
                LSQ_READY: begin
                    // one load in flight at most, order kept by stalling
                    if (has_head && !head_store && port.accepted) begin
                        state <= LSQ_WAIT;
                    end
                end
                LSQ_WAIT: begin
                    if (port.reply_valid) begin
                        state <= LSQ_READY;
                    end
                end
                default: begin
                    state <= LSQ_READY;
                end
            endcase
        end
    end

    // sender has to look at lsq_free first
    no_enq_when_full: assert property (@(posedge clock) disable iff (reset)
        mem_op_valid |-> lsq_free)
        else $error("memory op sent while queue full");

    // arbiter routes data replies only to our outstanding load
    no_stray_reply: assert property (@(posedge clock) disable iff (reset)
        port.reply_valid |-> (state == LSQ_WAIT))
        else $error("data reply while no load outstanding");

endmodule

`default_nettype wire

// File: design/mem_arbiter.sv
`default_nettype none

module mem_arbiter (
    input  wire logic                clock,
    input  wire logic                reset,
    mem_port_if.arbiter              fetch_port,
    mem_port_if.arbiter              data_port,
    output mem_pkg::bus_cmd_t        proc2mem_command,
    output mem_pkg::xlen_t           proc2mem_addr,
    output mem_pkg::block_t          proc2mem_data,
    output mem_pkg::mem_size_t       proc2mem_size,
    input  wire mem_pkg::mem_tag_t   mem2proc_response,
    input  wire mem_pkg::block_t     mem2proc_data,
    input  wire mem_pkg::mem_tag_t   mem2proc_tag
);

    // owner bit values in the tag table
    localparam logic OWN_FETCH = 1'b0;
    localparam logic OWN_DATA  = 1'b1;

    logic                             data_sel;
    logic                             req_taken;
    logic                             load_taken;
    mem_pkg::xlen_t                   sel_addr;
    mem_pkg::word_t                   sel_word;
    logic [mem_pkg::NUM_MEM_TAGS-1:0] own_valid;
    logic [mem_pkg::NUM_MEM_TAGS-1:0] own_data;
    logic                             reply_hit;
    logic                             reply_to_data;

    ////////////////////////////////////////////////////////////
    // request select
    ////////////////////////////////////////////////////////////

    // data port wins whenever it has a command up
    assign data_sel = data_port.command != mem_pkg::BUS_NONE;

    always_comb begin
        if (data_sel) begin
            proc2mem_command = data_port.command;
            proc2mem_size    = data_port.size;
            sel_addr         = data_port.addr;
            sel_word         = data_port.data;
        end else begin
            proc2mem_command = fetch_port.command;
            proc2mem_size    = fetch_port.size;
            sel_addr         = fetch_port.addr;
            sel_word         = fetch_port.data;
        end
    end

    assign proc2mem_addr = sel_addr;
    // store word goes to the half named by addr bit 2
    assign proc2mem_data = sel_addr[2] ? {sel_word, 32'h0} : {32'h0, sel_word};

    // nonzero response tag means memory took it
    assign req_taken  = (proc2mem_command != mem_pkg::BUS_NONE) && (mem2proc_response != '0);
    assign load_taken = req_taken && (proc2mem_command == mem_pkg::BUS_LOAD);

    // losing port never sees accepted
    assign data_port.accepted  = req_taken && data_sel;
    assign fetch_port.accepted = req_taken && !data_sel;

    ////////////////////////////////////////////////////////////
    // tag ownership table
    ////////////////////////////////////////////////////////////

    // clear on reply first, so a tag reused in the same cycle stays valid
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            own_valid <= '0;
        end else begin
            if (mem2proc_tag != '0) begin
                own_valid[mem2proc_tag] <= 1'b0;
            end
            if (load_taken) begin
                own_valid[mem2proc_response] <= 1'b1;
            end
        end
    end

    // owning port per tag
    always_ff @(posedge clock) begin
        if (load_taken) begin
            own_data[mem2proc_response] <= data_sel ? OWN_DATA : OWN_FETCH;
        end
    end

    ////////////////////////////////////////////////////////////
    // reply steering
    ////////////////////////////////////////////////////////////

    assign reply_hit     = (mem2proc_tag != '0) && own_valid[mem2proc_tag];
    assign reply_to_data = own_data[mem2proc_tag] == OWN_DATA;

    assign data_port.reply_valid  = reply_hit && reply_to_data;
    assign fetch_port.reply_valid = reply_hit && !reply_to_data;
    // block goes to both, strobe picks the owner
    assign data_port.reply_data   = mem2proc_data;
    assign fetch_port.reply_data  = mem2proc_data;

    // memory only replies to tags it handed out for loads
    reply_has_owner: assert property (@(posedge clock) disable iff (reset)
        (mem2proc_tag != '0) |-> own_valid[mem2proc_tag])
        else $error("reply tag %0d has no owner", mem2proc_tag);

    // memory must not hand out a tag still in flight
    tag_not_reused: assert property (@(posedge clock) disable iff (reset)
        load_taken |-> (!own_valid[mem2proc_response] || mem2proc_tag == mem2proc_response))
        else $error("tag %0d accepted while still outstanding", mem2proc_response);

endmodule

`default_nettype wire

// File: design/mem_pkg.sv
`default_nettype none

package mem_pkg;

    ////////////////////////////////////////////////////////////
    // widths with a meaning
    ////////////////////////////////////////////////////////////

    // byte address
    typedef logic [31:0] xlen_t;

    // one instruction or one data word
    typedef logic [31:0] word_t;

    // one memory bus beat, two words
    typedef logic [63:0] block_t;

    // memory transaction tag
    // zero means no tag, or a refused command
    typedef logic [3:0] mem_tag_t;

    // reorder tag that rides along with a memory op
    typedef logic [4:0] op_tag_t;

    ////////////////////////////////////////////////////////////
    // bus encodings
    ////////////////////////////////////////////////////////////

    // bus commands, same codes as the processor memory
    typedef logic [1:0] bus_cmd_t;
    localparam bus_cmd_t BUS_NONE  = 2'h0;
    localparam bus_cmd_t BUS_LOAD  = 2'h1;
    localparam bus_cmd_t BUS_STORE = 2'h2;

    // access sizes
    // byte and half codes exist on the bus, never issued here
    typedef logic [1:0] mem_size_t;
    localparam mem_size_t SIZE_WORD   = 2'h2;
    localparam mem_size_t SIZE_DOUBLE = 2'h3;

    // one entry per tag value, entry 0 never filled
    localparam int NUM_MEM_TAGS = 16;

endpackage

`default_nettype wire

// File: design/mem_port_if.sv
`default_nettype none

interface mem_port_if;

    // request side, a level held until accepted
    mem_pkg::bus_cmd_t  command;
    mem_pkg::xlen_t     addr;
    mem_pkg::word_t     data;
    mem_pkg::mem_size_t size;

    // same cycle as the request it answers
    logic               accepted;

    // one-cycle reply strobe, block valid with it
    logic               reply_valid;
    mem_pkg::block_t    reply_data;

    modport requester (
        output command, addr, data, size,
        input  accepted, reply_valid, reply_data
    );

    modport arbiter (
        input  command, addr, data, size,
        output accepted, reply_valid, reply_data
    );

endinterface

`default_nettype wire

// File: design/mem_subsystem.sv
`default_nettype none

module mem_subsystem #(
    parameter int             LSQ_DEPTH = 4,
    parameter mem_pkg::xlen_t RESET_PC  = '0
) (
    input  wire logic               clock,
    input  wire logic               reset,
    // fetch side
    input  wire logic               take_branch,
    input  wire mem_pkg::xlen_t     branch_target,
    output logic                    fetch_valid,
    output mem_pkg::xlen_t          fetch_pc,
    output mem_pkg::word_t          fetch_inst,
    // memory ops in program order
    input  wire logic               mem_op_valid,
    input  wire logic               mem_op_store,
    input  wire mem_pkg::xlen_t     mem_op_addr,
    input  wire mem_pkg::word_t     mem_op_data,
    input  wire mem_pkg::op_tag_t   mem_op_tag,
    output logic                    lsq_free,
    output logic                    load_done,
    output mem_pkg::op_tag_t        load_tag,
    output mem_pkg::word_t          load_data,
    // processor memory port
    output mem_pkg::bus_cmd_t       proc2mem_command,
    output mem_pkg::xlen_t          proc2mem_addr,
    output mem_pkg::block_t         proc2mem_data,
    output mem_pkg::mem_size_t      proc2mem_size,
    input  wire mem_pkg::mem_tag_t  mem2proc_response,
    input  wire mem_pkg::block_t    mem2proc_data,
    input  wire mem_pkg::mem_tag_t  mem2proc_tag
);

    // one port per requester into the arbiter
    mem_port_if fetch_port ();
    mem_port_if data_port ();

    fetch_unit #(
        .RESET_PC (RESET_PC)
    ) fetch_unit_i (
        .clock         (clock),
        .reset         (reset),
        .take_branch   (take_branch),
        .branch_target (branch_target),
        .port          (fetch_port),
        .fetch_valid   (fetch_valid),
        .fetch_pc      (fetch_pc),
        .fetch_inst    (fetch_inst)
    );

    load_store_queue #(
        .LSQ_DEPTH (LSQ_DEPTH)
    ) load_store_queue_i (
        .clock        (clock),
        .reset        (reset),
        .mem_op_valid (mem_op_valid),
        .mem_op_store (mem_op_store),
        .mem_op_addr  (mem_op_addr),
        .mem_op_data  (mem_op_data),
        .mem_op_tag   (mem_op_tag),
        .port         (data_port),
        .lsq_free     (lsq_free),
        .load_done    (load_done),
        .load_tag     (load_tag),
        .load_data    (load_data)
    );

    mem_arbiter mem_arbiter_i (
        .clock             (clock),
        .reset             (reset),
        .fetch_port        (fetch_port),
        .data_port         (data_port),
        .proc2mem_command  (proc2mem_command),
        .proc2mem_addr     (proc2mem_addr),
        .proc2mem_data     (proc2mem_data),
        .proc2mem_size     (proc2mem_size),
        .mem2proc_response (mem2proc_response),
        .mem2proc_data     (mem2proc_data),
        .mem2proc_tag      (mem2proc_tag)
    );

endmodule

`default_nettype wire

// File: sources.f
design/mem_pkg.sv
design/mem_port_if.sv
design/mem_arbiter.sv
design/fetch_unit.sv
design/load_store_queue.sv
design/mem_subsystem.sv
testbench/mem_model.sv
testbench/mem_subsystem_tb.sv

// File: testbench/mem_model.sv
`default_nettype none

module mem_model #(
    parameter int SEED = 32'hab1c
) (
    input  wire logic               clock,
    input  wire logic               reset,
    input  wire mem_pkg::bus_cmd_t  proc2mem_command,
    input  wire mem_pkg::xlen_t     proc2mem_addr,
    input  wire mem_pkg::block_t    proc2mem_data,
    output mem_pkg::mem_tag_t       mem2proc_response,
    output mem_pkg::block_t         mem2proc_data,
    output mem_pkg::mem_tag_t       mem2proc_tag
);

    localparam mem_pkg::word_t MEM_PATTERN = 32'h5a5a_0000;

    integer                           seed = SEED;
    // this cycle's command gets refused
    logic                             refuse;
    // tag handed out and not yet replied on the bus
    logic [mem_pkg::NUM_MEM_TAGS-1:0] busy;
    // tag still counting down to its reply
    logic [mem_pkg::NUM_MEM_TAGS-1:0] pending;
    int                               wait_left [mem_pkg::NUM_MEM_TAGS];
    mem_pkg::xlen_t                   load_addr [mem_pkg::NUM_MEM_TAGS];
    // only written words live here, the rest is the fill pattern
    mem_pkg::word_t                   store_words [mem_pkg::xlen_t];
    mem_pkg::mem_tag_t                free_tag;

    function automatic mem_pkg::word_t read_word(input mem_pkg::xlen_t addr);
        if (store_words.exists(addr)) begin
            return store_words[addr];
        end
        return addr ^ MEM_PATTERN;
    endfunction

    ////////////////////////////////////////////////////////////
    // acceptance
    ////////////////////////////////////////////////////////////

    // lowest free tag, zero when all are taken
    always_comb begin
        free_tag = '0;
        for (int t = mem_pkg::NUM_MEM_TAGS - 1; t >= 1; t--) begin
            if (!busy[t]) begin
                free_tag = mem_pkg::mem_tag_t'(t);
            end
        end
    end

    assign mem2proc_response = (proc2mem_command != mem_pkg::BUS_NONE && !refuse) ? free_tag
                                                                                  : '0;

    ////////////////////////////////////////////////////////////
    // replies and backing store
    ////////////////////////////////////////////////////////////

    always @(posedge clock or posedge reset) begin
        int                               pick;
        mem_pkg::xlen_t                   base;
        logic [mem_pkg::NUM_MEM_TAGS-1:0] busy_next;
        if (reset) begin
            refuse        <= 1'b0;
            busy          <= '0;
            pending       = '0;
            mem2proc_tag  <= '0;
            mem2proc_data <= '0;
        end else begin
            busy_next = busy;
            // reply on the bus now frees its tag at this edge
            if (mem2proc_tag != '0) begin
                busy_next[mem2proc_tag] = 1'b0;
            end
            // count down, lowest due tag goes out next cycle
            pick = 0;
            for (int t = 1; t < mem_pkg::NUM_MEM_TAGS; t++) begin
                if (pending[t] && wait_left[t] > 0) begin
                    wait_left[t] = wait_left[t] - 1;
                end else if (pending[t] && pick == 0) begin
                    pick = t;
                end
            end
            if (pick != 0) begin
                pending[pick] = 1'b0;
                base = load_addr[pick];
                mem2proc_data <= {read_word(base + 32'd4), read_word(base)};
            end else begin
                mem2proc_data <= '0;
            end
            mem2proc_tag <= mem_pkg::mem_tag_t'(pick);
            // command taken this cycle
            if (mem2proc_response != '0) begin
                if (proc2mem_command == mem_pkg::BUS_LOAD) begin
                    busy_next[mem2proc_response] = 1'b1;
                    pending[mem2proc_response]   = 1'b1;
                    // 1 to 8 cycles until the reply
                    wait_left[mem2proc_response] = $random(seed) & 7;
                    load_addr[mem2proc_response] = {proc2mem_addr[31:3], 3'b000};
                end else if (proc2mem_command == mem_pkg::BUS_STORE) begin
                    base = {proc2mem_addr[31:2], 2'b00};
                    store_words[base] = proc2mem_addr[2] ? proc2mem_data[63:32]
                                                         : proc2mem_data[31:0];
                end
            end
            busy   <= busy_next;
            // one in four refused
            refuse <= ($random(seed) & 3) == 0;
        end
    end

endmodule

`default_nettype wire

// File: testbench/mem_subsystem_tb.sv
`default_nettype none

module mem_subsystem_tb;

    localparam int             LSQ_DEPTH   = 4;
    localparam mem_pkg::xlen_t RESET_PC    = 32'h0;
    // data ops stay up here, branch targets below 4k
    localparam mem_pkg::xlen_t DATA_BASE   = 32'h0010_0000;
    localparam mem_pkg::word_t MEM_PATTERN = 32'h5a5a_0000;
    localparam int             NUM_OPS     = 300;
    localparam int             WAIT_LIMIT  = 200;

    logic                clock;
    logic                reset;
    logic                take_branch;
    mem_pkg::xlen_t      branch_target;
    logic                fetch_valid;
    mem_pkg::xlen_t      fetch_pc;
    mem_pkg::word_t      fetch_inst;
    logic                mem_op_valid;
    logic                mem_op_store;
    mem_pkg::xlen_t      mem_op_addr;
    mem_pkg::word_t      mem_op_data;
    mem_pkg::op_tag_t    mem_op_tag;
    logic                lsq_free;
    logic                load_done;
    mem_pkg::op_tag_t    load_tag;
    mem_pkg::word_t      load_data;
    mem_pkg::bus_cmd_t   proc2mem_command;
    mem_pkg::xlen_t      proc2mem_addr;
    mem_pkg::block_t     proc2mem_data;
    mem_pkg::mem_size_t  proc2mem_size;
    mem_pkg::mem_tag_t   mem2proc_response;
    mem_pkg::block_t     mem2proc_data;
    mem_pkg::mem_tag_t   mem2proc_tag;

    integer seed = 32'hab1c;

    // scoreboard state
    mem_pkg::word_t   shadow [64];
    mem_pkg::op_tag_t load_tag_q [$];
    mem_pkg::word_t   load_data_q [$];
    mem_pkg::xlen_t   store_addr_q [$];
    mem_pkg::word_t   store_data_q [$];
    mem_pkg::xlen_t   exp_pc      = RESET_PC;
    mem_pkg::op_tag_t next_tag    = '0;
    int               held        = 0;
    int               errors      = 0;
    int               fetch_count = 0;
    int               load_count  = 0;
    int               store_count = 0;
    logic             saw_full    = 1'b0;
    logic             saw_refill  = 1'b0;
    logic             hung        = 1'b0;

    mem_subsystem #(
        .LSQ_DEPTH (LSQ_DEPTH),
        .RESET_PC  (RESET_PC)
    ) mem_subsystem_i (
        .clock             (clock),
        .reset             (reset),
        .take_branch       (take_branch),
        .branch_target     (branch_target),
        .fetch_valid       (fetch_valid),
        .fetch_pc          (fetch_pc),
        .fetch_inst        (fetch_inst),
        .mem_op_valid      (mem_op_valid),
        .mem_op_store      (mem_op_store),
        .mem_op_addr       (mem_op_addr),
        .mem_op_data       (mem_op_data),
        .mem_op_tag        (mem_op_tag),
        .lsq_free          (lsq_free),
        .load_done         (load_done),
        .load_tag          (load_tag),
        .load_data         (load_data),
        .proc2mem_command  (proc2mem_command),
        .proc2mem_addr     (proc2mem_addr),
        .proc2mem_data     (proc2mem_data),
        .proc2mem_size     (proc2mem_size),
        .mem2proc_response (mem2proc_response),
        .mem2proc_data     (mem2proc_data),
        .mem2proc_tag      (mem2proc_tag)
    );

    mem_model mem_model_i (
        .clock             (clock),
        .reset             (reset),
        .proc2mem_command  (proc2mem_command),
        .proc2mem_addr     (proc2mem_addr),
        .proc2mem_data     (proc2mem_data),
        .mem2proc_response (mem2proc_response),
        .mem2proc_data     (mem2proc_data),
        .mem2proc_tag      (mem2proc_tag)
    );

    initial begin
        clock = 1'b0;
        forever #10 clock = ~clock;
    end

    task automatic log_mismatch(input string msg);
        errors++;
        $display("ERROR @%0t: %s", $time, msg);
    endtask

    ////////////////////////////////////////////////////////////
    // checks, sampled mid-cycle
    ////////////////////////////////////////////////////////////

    always @(negedge clock) begin : check_block
        mem_pkg::word_t lane;
        logic           store_taken;
        if (!reset) begin
            // fetched word follows the fill pattern, pc steps by 4
            if (fetch_valid) begin
                fetch_count++;
                assert (fetch_pc == exp_pc)
                    else log_mismatch($sformatf("fetch_pc %h, expected %h", fetch_pc, exp_pc));
                assert (fetch_inst == (exp_pc ^ MEM_PATTERN))
                    else log_mismatch($sformatf("fetch_inst %h at pc %h", fetch_inst, exp_pc));
            end
            if (take_branch) begin
                exp_pc = branch_target;
            end else if (fetch_valid) begin
                exp_pc = exp_pc + 32'd4;
            end

            // sizes and store lane on accepted commands
            store_taken = 1'b0;
            if (mem2proc_response != '0 && proc2mem_command == mem_pkg::BUS_LOAD) begin
                assert (proc2mem_size == mem_pkg::SIZE_DOUBLE)
                    else log_mismatch($sformatf("load size %0d", proc2mem_size));
            end
            if (mem2proc_response != '0 && proc2mem_command == mem_pkg::BUS_STORE) begin
                store_taken = 1'b1;
                store_count++;
                assert (proc2mem_size == mem_pkg::SIZE_WORD)
                    else log_mismatch($sformatf("store size %0d", proc2mem_size));
                lane = proc2mem_addr[2] ? proc2mem_data[63:32] : proc2mem_data[31:0];
                if (store_addr_q.size() == 0) begin
                    log_mismatch("store on the bus with none queued");
                end else begin
                    assert (proc2mem_addr == store_addr_q[0] && lane == store_data_q[0])
                        else log_mismatch($sformatf("store %h to %h, expected %h to %h",
                            lane, proc2mem_addr, store_data_q[0], store_addr_q[0]));
                    void'(store_addr_q.pop_front());
                    void'(store_data_q.pop_front());
                end
            end

            // load results in enqueue order
            if (load_done) begin
                load_count++;
                if (load_tag_q.size() == 0) begin
                    log_mismatch("load_done with no load queued");
                end else begin
                    assert (load_tag == load_tag_q[0])
                        else log_mismatch($sformatf("load_tag %0d, expected %0d",
                            load_tag, load_tag_q[0]));
                    assert (load_data == load_data_q[0])
                        else log_mismatch($sformatf("load_data %h, expected %h",
                            load_data, load_data_q[0]));
                    void'(load_tag_q.pop_front());
                    void'(load_data_q.pop_front());
                end
            end

            // occupancy as seen before this cycle's changes
            assert (lsq_free == (held < LSQ_DEPTH))
                else log_mismatch($sformatf("lsq_free %b with %0d entries held", lsq_free, held));
            if (!lsq_free) begin
                saw_full = 1'b1;
            end else if (saw_full) begin
                saw_refill = 1'b1;
            end

            // shadow memory in program order
            if (mem_op_valid) begin
                if (mem_op_store) begin
                    shadow[mem_op_addr[7:2]] = mem_op_data;
                    store_addr_q.push_back(mem_op_addr);
                    store_data_q.push_back(mem_op_data);
                end else begin
                    load_tag_q.push_back(mem_op_tag);
                    load_data_q.push_back(shadow[mem_op_addr[7:2]]);
                end
            end
            held = held + int'(mem_op_valid) - int'(store_taken) - int'(load_done);
        end
    end

    ////////////////////////////////////////////////////////////
    // stimulus
    ////////////////////////////////////////////////////////////

    task automatic wait_free();
        int n;
        n = 0;
        @(negedge clock);
        while (!lsq_free && n < WAIT_LIMIT) begin
            @(negedge clock);
            n++;
        end
        if (!lsq_free) begin
            hung = 1'b1;
            errors++;
            $display("timeout: queue stayed full for %0d cycles", WAIT_LIMIT);
        end
    endtask

    // one op, sometimes with a branch, then a quiet cycle
    task automatic send_op();
        logic           store;
        mem_pkg::xlen_t addr;
        store = ($random(seed) & 3) == 0;
        addr  = DATA_BASE | {24'h0, 6'($random(seed)), 2'b00};
        @(posedge clock);
        mem_op_valid <= 1'b1;
        mem_op_store <= store;
        mem_op_addr  <= addr;
        mem_op_data  <= $random(seed);
        mem_op_tag   <= next_tag;
        next_tag = next_tag + 5'd1;
        if (($random(seed) & 15) == 0) begin
            take_branch   <= 1'b1;
            branch_target <= 32'($random(seed)) & 32'h0000_0ffc;
        end
        @(posedge clock);
        mem_op_valid <= 1'b0;
        take_branch  <= 1'b0;
    endtask

    task automatic wait_drain();
        int n;
        n = 0;
        @(negedge clock);
        while (held != 0 && n < WAIT_LIMIT) begin
            @(negedge clock);
            n++;
        end
        if (held != 0) begin
            hung = 1'b1;
            errors++;
            $display("timeout: queue did not drain, %0d entries left", held);
        end
    endtask

    initial begin
        for (int i = 0; i < 64; i++) begin
            shadow[i] = (DATA_BASE + 32'(i * 4)) ^ MEM_PATTERN;
        end
        reset         = 1'b1;
        take_branch   = 1'b0;
        branch_target = '0;
        mem_op_valid  = 1'b0;
        mem_op_store  = 1'b0;
        mem_op_addr   = '0;
        mem_op_data   = '0;
        mem_op_tag    = '0;
        repeat (5) @(posedge clock);
        reset <= 1'b0;

        for (int i = 0; i < NUM_OPS && !hung; i++) begin
            wait_free();
            if (!hung) begin
                send_op();
            end
        end
        if (!hung) begin
            wait_drain();
        end

        // the run has to have reached the interesting cases
        if (!saw_full || !saw_refill) begin
            errors++;
            $display("queue was never filled and freed again");
        end
        if (fetch_count == 0 || load_count == 0 || store_count == 0) begin
            errors++;
            $display("no fetch, load or store ever completed");
        end

        $display("checks done: %0d fetches, %0d loads, %0d stores, %0d errors",
                 fetch_count, load_count, store_count, errors);
        if (errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
